/* design/evrPkg.sv */
// Event receiver shared definitions

package evrPkg;

    //////////////////////////////////////////////////////////////////////
    // link and alignment
    localparam logic [7:0] COMMA_CHAR = 8'hBC;  // K28.5
    localparam int COMMAS_NEEDED = 60;          // clean commas before aligned
    localparam int COMMA_RELOAD = COMMAS_NEEDED - 1;
    localparam int COMMA_WIDTH = $clog2(COMMAS_NEEDED) + 1;  // msb is the aligned flag

    //////////////////////////////////////////////////////////////////////
    // event codes and markers
    localparam logic [7:0] PPS_CODE = 8'd125;
    localparam logic [7:0] HB_CODE = 8'd122;
    localparam int PPS_STRETCH_CYCLES = 60;
    localparam int HB_STRETCH_CYCLES = 400;  // shortened heartbeat for simulation
    // one counter width covers both stretchers
    localparam int STRETCH_WIDTH = $clog2(HB_STRETCH_CYCLES + 1);

    localparam int TRIGGER_COUNT = 8;
    localparam int TICK_WIDTH = 32;  // evrClk cycles since last PPS

    //////////////////////////////////////////////////////////////////////
    // monitor queue
    localparam int MON_DEPTH = 8;
    localparam int MON_PTR_WIDTH = $clog2(MON_DEPTH);
    localparam int MON_COUNT_WIDTH = MON_PTR_WIDTH + 1;  // holds 0..MON_DEPTH
    localparam int MON_CREDITS = 4;
    localparam int CREDIT_WIDTH = $clog2(MON_CREDITS + 1);

    //////////////////////////////////////////////////////////////////////
    // one received word, raw bits or dbus/code byte pair
    typedef union packed {
        logic [15:0] raw;
        struct packed {
            logic [7:0] dbus;  // distributed bus byte
            logic [7:0] code;  // event code, also where commas land
        } bytes;
    } evrWordU;

    typedef struct packed {
        evrWordU word;
        logic [1:0] isK;
        logic [1:0] notInTable;
        logic [1:0] dispErr;
    } rxWordS;  // 22 bits from the 8b/10b decoder

    typedef struct packed {
        evrWordU word;
        logic [1:0] isK;
    } charsS;  // 18 bits, zero unless aligned and clean

    typedef struct packed {
        logic monitor;                    // queue this code
        logic [TRIGGER_COUNT-1:0] trig;
    } actionS;

    typedef struct packed {
        logic en;
        logic [7:0] addr;  // event code to program
        actionS action;
    } actWrS;

    typedef struct packed {
        logic [7:0] code;
        logic [TICK_WIDTH-1:0] ticks;
    } monEntryS;

endpackage

/* design/commaAligner.sv */
// Comma alignment and character gating

`timescale 1ns/1ps

module commaAligner (
    input  logic           evrClk,
    input  logic           reset_i,
    input  evrPkg::rxWordS rxWord_i,
    output evrPkg::charsS  chars_o,
    output logic           aligned_o
);

    import evrPkg::*;

    //////////////////////////////////////////////////////////////////////
    // comma counter
    // loaded with COMMAS_NEEDED-1, counts down once per clean comma,
    // the wrap past zero sets the msb and that is the aligned flag
    logic [COMMA_WIDTH-1:0] commaCounter;
    logic rxAligned;
    logic rxDataErr;
    logic isComma;

    assign rxAligned = commaCounter[COMMA_WIDTH-1];
    assign aligned_o = rxAligned;

    // K is only legal on the low byte
    assign rxDataErr = (rxWord_i.notInTable != 2'b00)
                    || (rxWord_i.dispErr != 2'b00)
                    || rxWord_i.isK[1];

    // comma check looks at the raw view, low byte only
    assign isComma = rxWord_i.isK[0] && (rxWord_i.word.raw[7:0] == COMMA_CHAR);

    always_ff @(posedge evrClk) begin
        if (reset_i) begin
            commaCounter <= COMMA_WIDTH'(COMMA_RELOAD);
        end
        else if (rxDataErr) begin
            commaCounter <= COMMA_WIDTH'(COMMA_RELOAD);  // start over
        end
        else if (!rxAligned && isComma) begin
            commaCounter <= commaCounter - COMMA_WIDTH'(1);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // character stream
    // only words seen while already aligned get through, so a bad word
    // blanks its own slot and the flag drops in the same cycle
    always_ff @(posedge evrClk) begin
        if (reset_i) begin
            chars_o <= '0;
        end
        else if (rxAligned && !rxDataErr) begin
            chars_o.word <= rxWord_i.word;
            chars_o.isK <= rxWord_i.isK;
        end
        else begin
            chars_o <= '0;  // blank while hunting or on error
        end
    end

endmodule

/* design/eventDecoder.sv */
// Event code decode, actions and markers

`timescale 1ns/1ps

module eventDecoder (
    input  logic                              evrClk,
    input  logic                              reset_i,
    input  evrPkg::charsS                     chars_i,
    input  evrPkg::actWrS                     actWr_i,
    output logic [7:0]                        evrCode_o,
    output logic                              evrCodeValid_o,
    output logic [7:0]                        evrDbus_o,
    output logic [evrPkg::TRIGGER_COUNT-1:0]  trigger_o,
    output logic                              ppsMarker_o,
    output logic                              hbMarker_o,
    output logic                              monPush_o,
    output evrPkg::monEntryS                  monEntry_o
);

    import evrPkg::*;

    // reload on hit, else run down to zero
    function automatic logic [STRETCH_WIDTH-1:0] stretchNext(
        input logic [STRETCH_WIDTH-1:0] count,
        input logic                     hit,
        input logic [STRETCH_WIDTH-1:0] length
    );
        if (hit) begin
            return length;
        end
        if (count != '0) begin
            return count - STRETCH_WIDTH'(1);
        end
        return count;
    endfunction

    actionS actTable [256];  // indexed by event code
    actionS actEntry;
    logic goodCode;
    logic [TICK_WIDTH-1:0] tickCount;
    logic [STRETCH_WIDTH-1:0] ppsCount;
    logic [STRETCH_WIDTH-1:0] hbCount;

    //////////////////////////////////////////////////////////////////////
    // code extraction, one cycle after chars
    assign goodCode = (chars_i.word.bytes.code != 8'h00) && !chars_i.isK[0];

    always_ff @(posedge evrClk) begin
        if (reset_i) begin
            evrCode_o <= 8'h00;
            evrCodeValid_o <= 1'b0;
        end
        else begin
            evrCode_o <= goodCode ? chars_i.word.bytes.code : 8'h00;  // commas read as 0
            evrCodeValid_o <= goodCode;
        end
        evrDbus_o <= chars_i.word.bytes.dbus;  // bus byte rides in every word
    end

    //////////////////////////////////////////////////////////////////////
    // action table
    always_ff @(posedge evrClk) begin
        if (reset_i) begin
            for (int i = 0; i < 256; i++) begin
                actTable[i] <= '0;
            end
        end
        else if (actWr_i.en) begin
            actTable[actWr_i.addr] <= actWr_i.action;
        end
    end

    assign actEntry = actTable[evrCode_o];  // lookup while the code is shown

    always_ff @(posedge evrClk) begin
        if (reset_i) begin
            trigger_o <= '0;
            monPush_o <= 1'b0;
        end
        else begin
            trigger_o <= evrCodeValid_o ? actEntry.trig : '0;
            monPush_o <= evrCodeValid_o && actEntry.monitor;
        end
        monEntry_o.code <= evrCode_o;
        monEntry_o.ticks <= tickCount;  // count as of the code cycle
    end

    //////////////////////////////////////////////////////////////////////
    // ticks since PPS and marker stretchers
    always_ff @(posedge evrClk) begin
        if (reset_i) begin
            tickCount <= '0;
            ppsCount <= '0;
            hbCount <= '0;
        end
        else begin
            tickCount <= (evrCode_o == PPS_CODE) ? '0 : tickCount + TICK_WIDTH'(1);
            ppsCount <= stretchNext(ppsCount, evrCode_o == PPS_CODE,
                                    STRETCH_WIDTH'(PPS_STRETCH_CYCLES));
            hbCount <= stretchNext(hbCount, evrCode_o == HB_CODE,
                                   STRETCH_WIDTH'(HB_STRETCH_CYCLES));
        end
    end

    assign ppsMarker_o = ppsCount != '0;  // high for the full stretch length
    assign hbMarker_o = hbCount != '0;

endmodule

/* design/monitorQueue.sv */
// Monitored event FIFO with credit sender

`timescale 1ns/1ps

module monitorQueue (
    input  logic             evrClk,
    input  logic             reset_i,
    input  logic             push_i,
    input  evrPkg::monEntryS entry_i,
    input  logic             monCredit_i,
    output logic             monValid_o,
    output evrPkg::monEntryS monEntry_o,
    output logic             monDropped_o
);

    import evrPkg::*;

    monEntryS fifoMem [MON_DEPTH];  // entry storage
    logic [MON_PTR_WIDTH-1:0] wrPtr;
    logic [MON_PTR_WIDTH-1:0] rdPtr;
    logic [MON_COUNT_WIDTH-1:0] monCount;  // entries held
    logic [CREDIT_WIDTH-1:0] credits;      // entries the consumer can take
    logic full;
    logic empty;
    logic accept;
    logic send;

    //////////////////////////////////////////////////////////////////////
    // flags
    assign full = monCount == MON_COUNT_WIDTH'(MON_DEPTH);
    assign empty = monCount == '0;
    assign accept = push_i && !full;       // push into a full queue is lost
    assign send = !empty && (credits != '0);

    // head of queue goes straight out, one entry per credit
    assign monValid_o = send;
    assign monEntry_o = fifoMem[rdPtr];

    //////////////////////////////////////////////////////////////////////
    // storage
    always_ff @(posedge evrClk) begin
        if (accept) begin
            fifoMem[wrPtr] <= entry_i;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // pointers and occupancy
    always_ff @(posedge evrClk) begin
        if (reset_i) begin
            wrPtr <= '0;
            rdPtr <= '0;
            monCount <= '0;
        end
        else begin
            if (accept) begin
                wrPtr <= wrPtr + MON_PTR_WIDTH'(1);  // depth is a power of two
            end
            if (send) begin
                rdPtr <= rdPtr + MON_PTR_WIDTH'(1);
            end
            case ({accept, send})
                2'b10: monCount <= monCount + MON_COUNT_WIDTH'(1);
                2'b01: monCount <= monCount - MON_COUNT_WIDTH'(1);
                default: monCount <= monCount;  // none, or in and out together
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // credit counter
    // starts full, each send spends one, each returned pulse restores one
    always_ff @(posedge evrClk) begin
        if (reset_i) begin
            credits <= CREDIT_WIDTH'(MON_CREDITS);
        end
        else begin
            case ({send, monCredit_i})
                2'b10: credits <= credits - CREDIT_WIDTH'(1);
                2'b01: credits <= credits + CREDIT_WIDTH'(1);
                default: credits <= credits;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // overflow flag
    always_ff @(posedge evrClk) begin
        if (reset_i) begin
            monDropped_o <= 1'b0;
        end
        else if (push_i && full) begin
            monDropped_o <= 1'b1;  // sticky until reset
        end
    end

endmodule

/* design/evrRx.sv */
// Event receiver core top level

`timescale 1ns/1ps

module evrRx (
    input  logic                              evrClk,
    input  logic                              reset_i,
    input  evrPkg::rxWordS                    rxWord_i,
    input  evrPkg::actWrS                     actWr_i,
    input  logic                              monCredit_i,
    output logic                              aligned_o,
    output logic [7:0]                        evrCode_o,
    output logic                              evrCodeValid_o,
    output logic [7:0]                        evrDbus_o,
    output logic [evrPkg::TRIGGER_COUNT-1:0]  trigger_o,
    output logic                              ppsMarker_o,
    output logic                              hbMarker_o,
    output logic                              monValid_o,
    output evrPkg::monEntryS                  monEntry_o,
    output logic                              monDropped_o
);

    import evrPkg::*;

    charsS chars;          // aligned characters
    logic monPush;         // monitored code seen
    monEntryS monEntry;    // code and ticks for the queue

    //////////////////////////////////////////////////////////////////////
    // input side, decoded link words in
    commaAligner i_commaAligner (
        .evrClk    (evrClk),
        .reset_i   (reset_i),
        .rxWord_i  (rxWord_i),
        .chars_o   (chars),
        .aligned_o (aligned_o)
    );

    //////////////////////////////////////////////////////////////////////
    // codes, bus byte, triggers, markers
    eventDecoder i_eventDecoder (
        .evrClk         (evrClk),
        .reset_i        (reset_i),
        .chars_i        (chars),
        .actWr_i        (actWr_i),
        .evrCode_o      (evrCode_o),
        .evrCodeValid_o (evrCodeValid_o),
        .evrDbus_o      (evrDbus_o),
        .trigger_o      (trigger_o),
        .ppsMarker_o    (ppsMarker_o),
        .hbMarker_o     (hbMarker_o),
        .monPush_o      (monPush),
        .monEntry_o     (monEntry)
    );

    //////////////////////////////////////////////////////////////////////
    // output side, credit link to the consumer
    monitorQueue i_monitorQueue (
        .evrClk       (evrClk),
        .reset_i      (reset_i),
        .push_i       (monPush),
        .entry_i      (monEntry),
        .monCredit_i  (monCredit_i),
        .monValid_o   (monValid_o),
        .monEntry_o   (monEntry_o),
        .monDropped_o (monDropped_o)
    );

endmodule

/* dv/evrRx_asserts.sv */
// Event receiver bound assertions

`timescale 1ns/1ps

module evrRx_asserts (
    input logic                                evrClk,
    input logic                                reset_i,
    input logic [evrPkg::CREDIT_WIDTH-1:0]     credits,
    input logic                                monValid,
    input logic                                monCredit,
    input evrPkg::charsS                       chars,
    input logic                                aligned,
    input logic                                codeValid,
    input logic [7:0]                          code
);

    import evrPkg::*;

    int linkCredits;  // credits as counted from the link side

    always_ff @(posedge evrClk) begin
        if (reset_i) begin
            linkCredits <= MON_CREDITS;
        end
        else begin
            linkCredits <= linkCredits - int'(monValid) + int'(monCredit);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // credit link
    creditLimit: assert property (@(posedge evrClk) disable iff (reset_i)
        credits <= CREDIT_WIDTH'(MON_CREDITS))
        else $error("credit count above the granted number");

    sendNeedsCredit: assert property (@(posedge evrClk) disable iff (reset_i)
        monValid |-> linkCredits > 0)
        else $error("entry sent with no credit left");

    //////////////////////////////////////////////////////////////////////
    // decode side
    validCodeNonzero: assert property (@(posedge evrClk) disable iff (reset_i)
        codeValid |-> code != 8'h00)
        else $error("valid flag raised on a zero code");

    blankWhileHunting: assert property (@(posedge evrClk) disable iff (reset_i)
        !aligned |-> chars == '0)
        else $error("characters passed while unaligned");

endmodule

/* dv/evrRxChecker.sv */
// Event receiver reference model and checks

`timescale 1ns/1ps

module evrRxChecker (
    input  logic                              evrClk,
    input  logic                              reset_i,
    input  evrPkg::rxWordS                    rxWord_i,
    input  evrPkg::actWrS                     actWr_i,
    input  logic                              monCredit_i,
    input  logic                              aligned_i,
    input  logic [7:0]                        evrCode_i,
    input  logic                              evrCodeValid_i,
    input  logic [7:0]                        evrDbus_i,
    input  logic [evrPkg::TRIGGER_COUNT-1:0]  trigger_i,
    input  logic                              ppsMarker_i,
    input  logic                              hbMarker_i,
    input  logic                              monValid_i,
    input  evrPkg::monEntryS                  monEntry_i,
    input  logic                              monDropped_i,
    output int                                errCount_o [5],
    output int                                entries_o
);

    import evrPkg::*;

    // 0 alignment, 1 code/bus, 2 triggers, 3 queue, 4 markers
    int errCount [5];
    int entries;
    bit seenClock;

    // model state, one register per DUT stage
    int mCnt;                 // clean commas seen while hunting
    logic mAligned;
    charsS mChars;
    logic [7:0] mCode;
    logic mValid;
    logic [7:0] mDbus;
    logic [TRIGGER_COUNT-1:0] mTrig;
    logic mPush;
    monEntryS mEntry;
    logic [TICK_WIDTH-1:0] mTicks;
    int mPps;
    int mHb;
    actionS mTable [256];
    monEntryS mQ [$];
    int mCredits;
    logic mDropped;

    assign errCount_o = errCount;
    assign entries_o = entries;

    task automatic checkValue(input int testId, input string name,
                              input logic [63:0] expv, input logic [63:0] actv);
        if (expv !== actv) begin
            errCount[testId]++;
            $display("error %s: expected %0h actual %0h at %0t", name, expv, actv, $time);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // model step, inputs are stable at the rising edge
    always @(posedge evrClk) begin
        logic err;
        logic comma;
        logic good;
        logic send;
        logic full;
        actionS act;
        seenClock = 1'b1;
        if (reset_i) begin
            mCnt = 0;
            mAligned = 1'b0;
            mChars = '0;
            mCode = '0;
            mValid = 1'b0;
            mDbus = '0;
            mTrig = '0;
            mPush = 1'b0;
            mEntry = '0;
            mTicks = '0;
            mPps = 0;
            mHb = 0;
            foreach (mTable[i]) mTable[i] = '0;
            mQ.delete();
            mCredits = MON_CREDITS;
            mDropped = 1'b0;
        end
        else begin
            err = (rxWord_i.notInTable != 0) || (rxWord_i.dispErr != 0) || rxWord_i.isK[1];
            comma = rxWord_i.isK[0] && (rxWord_i.word.bytes.code == COMMA_CHAR);
            good = (mChars.word.bytes.code != 0) && !mChars.isK[0];
            act = mTable[mCode];  // old table, write lands after
            send = (mQ.size() > 0) && (mCredits > 0);

            // queue and credits, full judged before the pop
            full = (mQ.size() == MON_DEPTH);
            if (mPush && full) mDropped = 1'b1;
            if (send) void'(mQ.pop_front());
            if (mPush && !full) mQ.push_back(mEntry);
            if (send && !monCredit_i) mCredits--;
            if (monCredit_i && !send) mCredits++;

            // ticks and stretchers see the shown code
            mPps = (mCode == PPS_CODE) ? PPS_STRETCH_CYCLES : ((mPps > 0) ? mPps - 1 : 0);
            mHb = (mCode == HB_CODE) ? HB_STRETCH_CYCLES : ((mHb > 0) ? mHb - 1 : 0);
            mEntry = {mCode, mTicks};
            mTicks = (mCode == PPS_CODE) ? '0 : mTicks + 1'b1;
            mTrig = mValid ? act.trig : '0;
            mPush = mValid && act.monitor;

            mCode = good ? mChars.word.bytes.code : 8'h00;
            mValid = good;
            mDbus = mChars.word.bytes.dbus;
            mChars = (mAligned && !err) ? {rxWord_i.word, rxWord_i.isK} : '0;

            if (err) begin
                mCnt = 0;  // hunt again
                mAligned = 1'b0;
            end
            else if (!mAligned && comma) begin
                mCnt++;
                if (mCnt == COMMAS_NEEDED) mAligned = 1'b1;
            end

            if (actWr_i.en) mTable[actWr_i.addr] = actWr_i.action;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // compare on the falling edge, outputs settled
    always @(negedge evrClk) begin
        logic expValid;
        if (seenClock) begin
            checkValue(0, "alignment", 64'(mAligned), 64'(aligned_i));
            checkValue(1, "code valid", 64'(mValid), 64'(evrCodeValid_i));
            checkValue(1, "event code", 64'(mCode), 64'(evrCode_i));
            if (mValid) checkValue(1, "bus byte", 64'(mDbus), 64'(evrDbus_i));
            checkValue(2, "triggers", 64'(mTrig), 64'(trigger_i));
            checkValue(4, "pps marker", 64'(mPps > 0), 64'(ppsMarker_i));
            checkValue(4, "hb marker", 64'(mHb > 0), 64'(hbMarker_i));
            expValid = (mQ.size() > 0) && (mCredits > 0);
            checkValue(3, "queue valid", 64'(expValid), 64'(monValid_i));
            if (expValid && monValid_i) begin
                checkValue(3, "queue entry", 64'(mQ[0]), 64'(monEntry_i));
                entries++;
            end
            checkValue(3, "queue dropped", 64'(mDropped), 64'(monDropped_i));
        end
    end

endmodule

/* dv/evrRxTb.sv */
// Event receiver testbench

`timescale 1ns/1ps

module evrRxTb;

    import evrPkg::*;

    localparam int ACT_CYCLES = 256;      // one write per table entry
    localparam int ALIGN_CYCLES = 70;
    localparam int TRAFFIC_CYCLES = 3000;
    localparam int DRAIN_CYCLES = 500;    // longer than the heartbeat stretch
    localparam int CYCLE_LIMIT = 3 + ACT_CYCLES + ALIGN_CYCLES + TRAFFIC_CYCLES
                                 + DRAIN_CYCLES + 1000;

    logic evrClk;
    logic reset_i;
    rxWordS rxWord_i;
    actWrS actWr_i;
    logic monCredit_i;
    logic aligned_o;
    logic [7:0] evrCode_o;
    logic evrCodeValid_o;
    logic [7:0] evrDbus_o;
    logic [TRIGGER_COUNT-1:0] trigger_o;
    logic ppsMarker_o;
    logic hbMarker_o;
    logic monValid_o;
    monEntryS monEntry_o;
    logic monDropped_o;

    int errCount [5];
    int entries;
    int totalErrors;
    int cycleCount;
    int received;      // entries offered to the consumer
    int returned;      // credits handed back
    int creditDiv;     // one credit per this many cycles on average
    logic [31:0] rngState;

    evrRx i_evrRx (.*);

    evrRxChecker i_evrRxChecker (
        .evrClk         (evrClk),
        .reset_i        (reset_i),
        .rxWord_i       (rxWord_i),
        .actWr_i        (actWr_i),
        .monCredit_i    (monCredit_i),
        .aligned_i      (aligned_o),
        .evrCode_i      (evrCode_o),
        .evrCodeValid_i (evrCodeValid_o),
        .evrDbus_i      (evrDbus_o),
        .trigger_i      (trigger_o),
        .ppsMarker_i    (ppsMarker_o),
        .hbMarker_i     (hbMarker_o),
        .monValid_i     (monValid_o),
        .monEntry_i     (monEntry_o),
        .monDropped_i   (monDropped_o),
        .errCount_o     (errCount),
        .entries_o      (entries)
    );

    //////////////////////////////////////////////////////////////////////
    // assertions, unused ports tied to values that always hold
    bind monitorQueue evrRx_asserts a_queue (.evrClk(evrClk), .reset_i(reset_i),
        .credits(credits), .monValid(monValid_o), .monCredit(monCredit_i),
        .chars('0), .aligned(1'b1), .codeValid(1'b0), .code(8'h00));
    bind commaAligner evrRx_asserts a_aligner (.evrClk(evrClk), .reset_i(reset_i),
        .credits('0), .monValid(1'b0), .monCredit(1'b0), .chars(chars_o),
        .aligned(aligned_o), .codeValid(1'b0), .code(8'h00));
    bind eventDecoder evrRx_asserts a_decoder (.evrClk(evrClk), .reset_i(reset_i),
        .credits('0), .monValid(1'b0), .monCredit(1'b0), .chars('0), .aligned(1'b1),
        .codeValid(evrCodeValid_o), .code(evrCode_o));

    always #5 evrClk = ~evrClk;  // 10 ns period

    function automatic logic [15:0] nextRand();
        rngState = rngState * 32'd1103515245 + 32'd12345;
        return rngState[30:15];
    endfunction

    function automatic rxWordS commaWord(input logic [7:0] dbus);
        rxWordS w;
        w = '0;
        w.word.bytes.dbus = dbus;
        w.word.bytes.code = COMMA_CHAR;
        w.isK = 2'b01;
        return w;
    endfunction

    // one cycle of stimulus, driven on the falling edge
    task automatic stepCycle(input rxWordS word, input actWrS wr);
        @(negedge evrClk);
        rxWord_i = word;
        actWr_i = wr;
        if (monValid_o) received++;  // consumed at the next rising edge
        monCredit_i = 1'b0;
        if ((received > returned) && (int'(nextRand()) % creditDiv == 0)) begin
            monCredit_i = 1'b1;
            returned++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // timeout
    always @(posedge evrClk) begin
        cycleCount++;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        rxWordS w;
        actWrS wr;
        int pick;
        evrClk = 1'b0;
        reset_i = 1'b1;
        rxWord_i = '0;
        actWr_i = '0;
        monCredit_i = 1'b0;
        rngState = 32'd53;
        cycleCount = 0;
        received = 0;
        returned = 0;
        creditDiv = 8;
        repeat (3) @(posedge evrClk);
        @(negedge evrClk);
        reset_i = 1'b0;

        // phase 1, every table entry incl. PPS and HB
        for (int a = 0; a < ACT_CYCLES; a++) begin
            wr.en = 1'b1;
            wr.addr = 8'(a);
            wr.action = 9'(nextRand());
            stepCycle('0, wr);
        end

        // phase 2, commas to gain lock
        for (int i = 0; i < ALIGN_CYCLES; i++) begin
            stepCycle(commaWord(8'(nextRand())), '0);
        end

        // phase 3, mixed traffic with rare errors and table rewrites
        for (int i = 0; i < TRAFFIC_CYCLES; i++) begin
            pick = int'(nextRand()) % 400;
            w = commaWord(8'(nextRand()));
            if (pick == 0) begin
                case (int'(nextRand()) % 3)
                    0: w.notInTable = 2'b10;
                    1: w.dispErr = 2'b01;
                    default: w.isK = 2'b11;  // K in the bus byte
                endcase
            end
            else if (pick >= 100) begin
                w.isK = 2'b00;
                if (pick < 104) w.word.bytes.code = PPS_CODE;
                else if (pick < 106) w.word.bytes.code = HB_CODE;
                else if (pick < 112) begin
                    w.isK = 2'b01;  // non-comma K, never a code
                    w.word.bytes.code = 8'(nextRand()) | 8'h01;
                end
                else w.word.bytes.code = 8'(nextRand());  // zero now and then
            end
            wr = '0;
            if (int'(nextRand()) % 32 == 0) begin
                wr.en = 1'b1;
                wr.addr = 8'(nextRand());
                wr.action = 9'(nextRand());
            end
            stepCycle(w, wr);
        end

        // phase 4, commas only and a fast consumer to drain the queue
        creditDiv = 2;
        for (int i = 0; i < DRAIN_CYCLES; i++) begin
            stepCycle(commaWord(8'(nextRand())), '0);
        end

        // counts settle after the last falling-edge compare
        @(negedge evrClk);
        @(posedge evrClk);
        totalErrors = errCount[0] + errCount[1] + errCount[2] + errCount[3] + errCount[4];
        $display("errors: align %0d code %0d trigger %0d queue %0d marker %0d, entries %0d",
                 errCount[0], errCount[1], errCount[2], errCount[3], errCount[4], entries);
        if (totalErrors == 0) begin
            $display("PASS: all tests");
        end
        else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* evrRx.f */
design/evrPkg.sv
design/commaAligner.sv
design/eventDecoder.sv
design/monitorQueue.sv
design/evrRx.sv
dv/evrRx_asserts.sv
dv/evrRxChecker.sv
dv/evrRxTb.sv

/* run.sh */
#!/bin/sh
# build the event receiver testbench with Verilator and run it once
verilator --binary --timing --assert -Wno-fatal \
    --top-module evrRxTb -f evrRx.f -o evrRxSim > /dev/null &&
simOut="$(./obj_dir/evrRxSim)" ; echo "$simOut" &&
echo "$simOut" | grep -q "PASS: all tests" && exit 0 || exit 1
